//--- vlog.f
logic/axi_chan_pkg.sv
logic/compare_pkg.sv
logic/stream_fork_2.sv
logic/cmp_fifo.sv
logic/aw_id_queues.sv
logic/mismatch_detect.sv
logic/bus_compare_top.sv
sim/tb_clock_gen.sv
sim/bus_compare_assertions.sv
sim/tb_checker.sv
sim/tb_bus_compare.sv

//--- Bender.yml
package:
  name: bus_compare

sources:
  - logic/axi_chan_pkg.sv
  - logic/compare_pkg.sv
  - logic/stream_fork_2.sv
  - logic/cmp_fifo.sv
  - logic/aw_id_queues.sv
  - logic/mismatch_detect.sv
  - logic/bus_compare_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/bus_compare_assertions.sv
      - sim/tb_checker.sv
      - sim/tb_bus_compare.sv

//--- sim/tb_bus_compare.sv
`timescale 1ns/1ns

module tb_bus_compare;

    import axi_chan_pkg::*;
    import compare_pkg::*;

    localparam int unsigned NumBeats   = 24;
    localparam int unsigned StallBeats = 12;
    localparam int unsigned TotalBeats = 3 * 4 * NumBeats + 2 * NumIds * AwDepth
                                         + 2 * StallBeats + 8;
    // 40 cycles of 8 ns per beat
    localparam int unsigned WatchdogNs = TotalBeats * 40 * 8;

    logic clk;
    logic rst_n;
    aw_chan_t a_aw, a_aw_out, b_aw, b_aw_out;
    w_chan_t  a_w, a_w_out, b_w, b_w_out;
    logic a_aw_valid, a_aw_ready, a_aw_out_valid, a_aw_out_ready;
    logic a_w_valid, a_w_ready, a_w_out_valid, a_w_out_ready;
    logic b_aw_valid, b_aw_ready, b_aw_out_valid, b_aw_out_ready;
    logic b_w_valid, b_w_ready, b_w_out_valid, b_w_out_ready;
    mismatch_t mismatch;
    logic      mismatch_any;
    logic      busy;

    tb_clock_gen i_clock_gen (.clk_o(clk), .rst_no(rst_n));

    bus_compare_top i_bus_compare_top (
        .clk_i(clk), .rst_ni(rst_n),
        .a_aw_i(a_aw), .a_aw_valid_i(a_aw_valid), .a_aw_ready_o(a_aw_ready),
        .a_aw_o(a_aw_out), .a_aw_valid_o(a_aw_out_valid), .a_aw_ready_i(a_aw_out_ready),
        .a_w_i(a_w), .a_w_valid_i(a_w_valid), .a_w_ready_o(a_w_ready),
        .a_w_o(a_w_out), .a_w_valid_o(a_w_out_valid), .a_w_ready_i(a_w_out_ready),
        .b_aw_i(b_aw), .b_aw_valid_i(b_aw_valid), .b_aw_ready_o(b_aw_ready),
        .b_aw_o(b_aw_out), .b_aw_valid_o(b_aw_out_valid), .b_aw_ready_i(b_aw_out_ready),
        .b_w_i(b_w), .b_w_valid_i(b_w_valid), .b_w_ready_o(b_w_ready),
        .b_w_o(b_w_out), .b_w_valid_o(b_w_out_valid), .b_w_ready_i(b_w_out_ready),
        .mismatch_o(mismatch), .mismatch_any_o(mismatch_any), .busy_o(busy)
    );

    tb_checker i_checker (
        .clk_i(clk), .rst_ni(rst_n),
        .a_aw_i(a_aw), .a_aw_out_i(a_aw_out), .b_aw_i(b_aw), .b_aw_out_i(b_aw_out),
        .a_w_i(a_w), .a_w_out_i(a_w_out), .b_w_i(b_w), .b_w_out_i(b_w_out),
        .a_aw_valid_i(a_aw_valid), .a_aw_ready_i(a_aw_ready),
        .a_aw_out_valid_i(a_aw_out_valid), .a_aw_out_ready_i(a_aw_out_ready),
        .a_w_valid_i(a_w_valid), .a_w_ready_i(a_w_ready),
        .a_w_out_valid_i(a_w_out_valid), .a_w_out_ready_i(a_w_out_ready),
        .b_aw_valid_i(b_aw_valid), .b_aw_ready_i(b_aw_ready),
        .b_aw_out_valid_i(b_aw_out_valid), .b_aw_out_ready_i(b_aw_out_ready),
        .b_w_valid_i(b_w_valid), .b_w_ready_i(b_w_ready),
        .b_w_out_valid_i(b_w_out_valid), .b_w_out_ready_i(b_w_out_ready),
        .mismatch_i(mismatch)
    );

    // --------------------------------------------------
    // Drivers
    // --------------------------------------------------
    task automatic send_aw(input bit side, input aw_chan_t q[$]);
        bit done;
        foreach (q[i]) begin
            done = 1'b0;
            if (side) {b_aw, b_aw_valid} = {q[i], 1'b1};
            else {a_aw, a_aw_valid} = {q[i], 1'b1};
            while (!done) begin
                @(negedge clk);
                done = side ? b_aw_ready : a_aw_ready;
                @(posedge clk);
                #1;
            end
            if (side) b_aw_valid = 1'b0;
            else a_aw_valid = 1'b0;
        end
    endtask

    task automatic send_w(input bit side, input w_chan_t q[$]);
        bit done;
        foreach (q[i]) begin
            done = 1'b0;
            if (side) {b_w, b_w_valid} = {q[i], 1'b1};
            else {a_w, a_w_valid} = {q[i], 1'b1};
            while (!done) begin
                @(negedge clk);
                done = side ? b_w_ready : a_w_ready;
                @(posedge clk);
                #1;
            end
            if (side) b_w_valid = 1'b0;
            else a_w_valid = 1'b0;
        end
    endtask

    function automatic aw_chan_t rand_aw(input int id);
        aw_chan_t aw;
        aw.id   = id_t'(id);
        aw.addr = $urandom;
        aw.len  = 8'($urandom_range(255));
        aw.size = 3'($urandom_range(2));
        return aw;
    endfunction

    function automatic w_chan_t rand_w();
        w_chan_t w;
        w.data = $urandom;
        w.strb = 4'($urandom);
        w.last = 1'($urandom);
        return w;
    endfunction

    // Queues empty and nothing pending, then two spare cycles for pulses
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < 500) begin
            @(negedge clk);
            n++;
        end
        if (busy) i_checker.report_error("queues did not drain");
        repeat (2) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // Random downstream ready, 3 out of 4 cycles
    initial begin
        {a_aw_out_ready, a_w_out_ready, b_aw_out_ready, b_w_out_ready} = '0;
        forever begin
            @(posedge clk);
            #1;
            a_aw_out_ready = ($urandom_range(3) != 0);
            a_w_out_ready  = ($urandom_range(3) != 0);
            b_aw_out_ready = ($urandom_range(3) != 0);
            b_w_out_ready  = ($urandom_range(3) != 0);
        end
    end

    initial begin
        #(WatchdogNs);
        $display("Watchdog expired after %0d ns, the run is stuck", WatchdogNs);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        aw_chan_t la[$];
        aw_chan_t lb[$];
        w_chan_t  wa[$];
        w_chan_t  wb[$];
        aw_chan_t tmp;
        int k;
        {a_aw, b_aw, a_w, b_w} = '0;
        {a_aw_valid, a_w_valid, b_aw_valid, b_w_valid} = '0;
        void'($urandom(32'h3f0795ef));
        @(posedge rst_n);

        i_checker.start_test("reset_idle");
        repeat (4) begin
            @(negedge clk);
            if (a_aw_out_valid || a_w_out_valid || b_aw_out_valid || b_w_out_valid
                || mismatch != '0 || mismatch_any || busy)
                i_checker.report_error("output active after reset before any beat");
        end
        i_checker.end_test();
        @(posedge clk);
        #1;

        for (int t = 0; t < 3; t++) begin
            la.delete();
            wa.delete();
            for (int i = 0; i < NumBeats; i++) begin
                la.push_back(rand_aw($urandom_range(NumIds - 1)));
                wa.push_back(rand_w());
            end
            lb = la;
            wb = wa;
            k = $urandom_range(NumBeats - 1);
            // Test 1 identical, test 2 one W byte, test 3 one address
            if (t == 1) wb[k].data[15:8] = wb[k].data[15:8] ^ 8'h5a;
            if (t == 2) lb[k].addr = lb[k].addr ^ 32'h1;
            i_checker.start_test(t == 0 ? "identical" : (t == 1 ? "corrupt_w" : "aw_addr"));
            fork
                send_aw(1'b0, la);
                send_aw(1'b1, lb);
                send_w(1'b0, wa);
                send_w(1'b1, wb);
            join
            wait_idle();
            i_checker.end_test();
        end

        // Random interleaving on A, grouped by ID on B
        la.delete();
        lb.delete();
        for (int i = 0; i < NumIds * AwDepth; i++) la.push_back(rand_aw(i % NumIds));
        for (int i = la.size() - 1; i > 0; i--) begin
            k = $urandom_range(i);
            tmp = la[i];
            la[i] = la[k];
            la[k] = tmp;
        end
        for (int id = 0; id < NumIds; id++)
            foreach (la[i]) if (la[i].id == id) lb.push_back(la[i]);
        i_checker.start_test("aw_reorder");
        fork
            send_aw(1'b0, la);
            send_aw(1'b1, lb);
        join
        wait_idle();
        i_checker.end_test();

        // Side B idle until side A's W queue is full
        wa.delete();
        for (int i = 0; i < StallBeats; i++) wa.push_back(rand_w());
        i_checker.start_test("w_stall");
        fork
            send_w(1'b0, wa);
            begin
                repeat (60) @(negedge clk);
                i_checker.check_value("accepted W beats with B idle", WDepth,
                                      i_checker.up_cnt[1]);
                if (a_w_ready) i_checker.report_error("side A W ready with full queue");
                @(posedge clk);
                #1;
                send_w(1'b1, wa);
            end
        join
        wait_idle();
        i_checker.end_test();

        $display("%0d tests run, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 i_checker.tests_run, i_checker.tests_run - i_checker.tests_failed,
                 i_checker.tests_failed, i_checker.errors,
                 i_bus_compare_top.i_bus_compare_assertions.fail_count);
        if (i_checker.errors == 0
            && i_bus_compare_top.i_bus_compare_assertions.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input logic                   clk_i,
    input logic                   rst_ni,
    input axi_chan_pkg::aw_chan_t a_aw_i, a_aw_out_i, b_aw_i, b_aw_out_i,
    input axi_chan_pkg::w_chan_t  a_w_i, a_w_out_i, b_w_i, b_w_out_i,
    input logic a_aw_valid_i, a_aw_ready_i, a_aw_out_valid_i, a_aw_out_ready_i,
    input logic a_w_valid_i, a_w_ready_i, a_w_out_valid_i, a_w_out_ready_i,
    input logic b_aw_valid_i, b_aw_ready_i, b_aw_out_valid_i, b_aw_out_ready_i,
    input logic b_w_valid_i, b_w_ready_i, b_w_out_valid_i, b_w_out_ready_i,
    input compare_pkg::mismatch_t mismatch_i
);

    import axi_chan_pkg::*;
    import compare_pkg::*;

    // Model queues of accepted beats
    aw_chan_t model_aw_a [NumIds][$];
    aw_chan_t model_aw_b [NumIds][$];
    w_chan_t  model_w_a [$];
    w_chan_t  model_w_b [$];

    // Index NumIds is the w bit
    int exp_cnt [NumIds+1];
    int act_cnt [NumIds+1];
    // Ports in order a_aw, a_w, b_aw, b_w
    int up_cnt [4];
    int ds_cnt [4];
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    string test_name = "none";

    task automatic report_error(input string msg);
        $display("ERROR in test %s: %s", test_name, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        for (int i = 0; i <= NumIds; i++) begin
            exp_cnt[i] = 0;
            act_cnt[i] = 0;
        end
        for (int i = 0; i < 4; i++) begin
            up_cnt[i] = 0;
            ds_cnt[i] = 0;
        end
    endtask

    task automatic end_test();
        for (int i = 0; i < NumIds; i++) begin
            check_value($sformatf("aw[%0d] pulses", i), exp_cnt[i], act_cnt[i]);
        end
        check_value("w pulses", exp_cnt[NumIds], act_cnt[NumIds]);
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("downstream beats on port %0d", i), up_cnt[i], ds_cnt[i]);
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %s: %s (%0d errors)", test_name, test_errors ? "FAIL" : "PASS",
                 test_errors);
    endtask

    // Upstream may only complete once the downstream branch is through
    task automatic check_stall(input logic ds_valid, input logic ds_ready,
                               input logic up_ready, input string port);
        if (ds_valid && !ds_ready && up_ready) begin
            report_error({port, " upstream ready high while downstream stalls"});
        end
    endtask

    // --------------------------------------------------
    // Monitor and model
    // --------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (a_aw_valid_i && a_aw_ready_i) begin
                model_aw_a[a_aw_i.id].push_back(a_aw_i);
                up_cnt[0]++;
            end
            if (a_w_valid_i && a_w_ready_i) begin
                model_w_a.push_back(a_w_i);
                up_cnt[1]++;
            end
            if (b_aw_valid_i && b_aw_ready_i) begin
                model_aw_b[b_aw_i.id].push_back(b_aw_i);
                up_cnt[2]++;
            end
            if (b_w_valid_i && b_w_ready_i) begin
                model_w_b.push_back(b_w_i);
                up_cnt[3]++;
            end
            ds_cnt[0] += (a_aw_out_valid_i && a_aw_out_ready_i && a_aw_out_i === a_aw_i);
            ds_cnt[1] += (a_w_out_valid_i && a_w_out_ready_i && a_w_out_i === a_w_i);
            ds_cnt[2] += (b_aw_out_valid_i && b_aw_out_ready_i && b_aw_out_i === b_aw_i);
            ds_cnt[3] += (b_w_out_valid_i && b_w_out_ready_i && b_w_out_i === b_w_i);
            check_stall(a_aw_out_valid_i, a_aw_out_ready_i, a_aw_ready_i, "side A AW");
            check_stall(a_w_out_valid_i, a_w_out_ready_i, a_w_ready_i, "side A W");
            check_stall(b_aw_out_valid_i, b_aw_out_ready_i, b_aw_ready_i, "side B AW");
            check_stall(b_w_out_valid_i, b_w_out_ready_i, b_w_ready_i, "side B W");
            for (int i = 0; i < NumIds; i++) begin
                act_cnt[i] += mismatch_i.aw[i];
                while (model_aw_a[i].size() > 0 && model_aw_b[i].size() > 0) begin
                    if (model_aw_a[i].pop_front() != model_aw_b[i].pop_front()) begin
                        exp_cnt[i]++;
                    end
                end
            end
            act_cnt[NumIds] += mismatch_i.w;
            while (model_w_a.size() > 0 && model_w_b.size() > 0) begin
                if (model_w_a.pop_front() != model_w_b.pop_front()) begin
                    exp_cnt[NumIds]++;
                end
            end
        end
    end

endmodule

//--- sim/bus_compare_assertions.sv
`timescale 1ns/1ns

module bus_compare_assertions (
    input logic                   clk_i,
    input logic                   rst_ni,
    input axi_chan_pkg::aw_chan_t a_aw_o,
    input logic                   a_aw_valid_o,
    input logic                   a_aw_ready_i,
    input axi_chan_pkg::w_chan_t  a_w_o,
    input logic                   a_w_valid_o,
    input logic                   a_w_ready_i,
    input axi_chan_pkg::aw_chan_t b_aw_o,
    input logic                   b_aw_valid_o,
    input logic                   b_aw_ready_i,
    input axi_chan_pkg::w_chan_t  b_w_o,
    input logic                   b_w_valid_o,
    input logic                   b_w_ready_i,
    input compare_pkg::mismatch_t mismatch_o,
    input logic                   mismatch_any_o,
    input logic                   busy_o
);

    // Failed assertion count
    int unsigned fail_count = 0;

    // Held beat keeps its payload until the transfer
    property p_hold(logic v, logic r, logic [63:0] d);
        @(posedge clk_i) disable iff (!rst_ni) (v && !r) |=> $stable(d);
    endproperty

    a_aw_a_hold: assert property (p_hold(a_aw_valid_o, a_aw_ready_i, 64'(a_aw_o)))
        else begin
            fail_count++;
            $error("side A AW payload changed while stalled");
        end
    a_w_a_hold: assert property (p_hold(a_w_valid_o, a_w_ready_i, 64'(a_w_o)))
        else begin
            fail_count++;
            $error("side A W payload changed while stalled");
        end
    a_aw_b_hold: assert property (p_hold(b_aw_valid_o, b_aw_ready_i, 64'(b_aw_o)))
        else begin
            fail_count++;
            $error("side B AW payload changed while stalled");
        end
    a_w_b_hold: assert property (p_hold(b_w_valid_o, b_w_ready_i, 64'(b_w_o)))
        else begin
            fail_count++;
            $error("side B W payload changed while stalled");
        end

    // A report needs a pair in the queues
    a_report_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mismatch_o != '0) |-> busy_o)
        else begin
            fail_count++;
            $error("mismatch bit high while not busy");
        end

    a_any_or: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mismatch_any_o == (|mismatch_o))
        else begin
            fail_count++;
            $error("mismatch_any_o differs from OR of mismatch_o");
        end

endmodule

bind bus_compare_top bus_compare_assertions i_bus_compare_assertions (.*);

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

//--- logic/bus_compare_top.sv
`timescale 1ns/1ns

module bus_compare_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Side A
    input  axi_chan_pkg::aw_chan_t a_aw_i,
    input  logic                   a_aw_valid_i,
    output logic                   a_aw_ready_o,
    output axi_chan_pkg::aw_chan_t a_aw_o,
    output logic                   a_aw_valid_o,
    input  logic                   a_aw_ready_i,
    input  axi_chan_pkg::w_chan_t  a_w_i,
    input  logic                   a_w_valid_i,
    output logic                   a_w_ready_o,
    output axi_chan_pkg::w_chan_t  a_w_o,
    output logic                   a_w_valid_o,
    input  logic                   a_w_ready_i,
    // Side B
    input  axi_chan_pkg::aw_chan_t b_aw_i,
    input  logic                   b_aw_valid_i,
    output logic                   b_aw_ready_o,
    output axi_chan_pkg::aw_chan_t b_aw_o,
    output logic                   b_aw_valid_o,
    input  logic                   b_aw_ready_i,
    input  axi_chan_pkg::w_chan_t  b_w_i,
    input  logic                   b_w_valid_i,
    output logic                   b_w_ready_o,
    output axi_chan_pkg::w_chan_t  b_w_o,
    output logic                   b_w_valid_o,
    input  logic                   b_w_ready_i,
    // Report
    output compare_pkg::mismatch_t mismatch_o,
    output logic                   mismatch_any_o,
    output logic                   busy_o
);

    import axi_chan_pkg::*;
    import compare_pkg::*;

    // Capture branch handshakes
    logic a_aw_cap_valid, a_aw_cap_ready;
    logic a_w_cap_valid, a_w_cap_ready;
    logic b_aw_cap_valid, b_aw_cap_ready;
    logic b_w_cap_valid, b_w_cap_ready;

    // Queue heads
    aw_chan_t [NumIds-1:0] aw_head_a, aw_head_b;
    logic     [NumIds-1:0] aw_head_valid_a, aw_head_valid_b;
    logic     [NumIds-1:0] aw_pop;
    w_chan_t               w_head_a, w_head_b;
    logic                  w_head_valid_a, w_head_valid_b;
    logic                  w_pop;

    // Payload passes straight through
    assign a_aw_o = a_aw_i;
    assign a_w_o  = a_w_i;
    assign b_aw_o = b_aw_i;
    assign b_w_o  = b_w_i;

    // --------------------------------------------------
    // Forks, bit 0 downstream and bit 1 capture
    // --------------------------------------------------
    stream_fork_2 i_fork_aw_a (
        .clk_i   ( clk_i                          ),
        .rst_ni  ( rst_ni                         ),
        .valid_i ( a_aw_valid_i                   ),
        .ready_o ( a_aw_ready_o                   ),
        .valid_o ( {a_aw_cap_valid, a_aw_valid_o} ),
        .ready_i ( {a_aw_cap_ready, a_aw_ready_i} )
    );

    stream_fork_2 i_fork_w_a (
        .clk_i   ( clk_i                        ),
        .rst_ni  ( rst_ni                       ),
        .valid_i ( a_w_valid_i                  ),
        .ready_o ( a_w_ready_o                  ),
        .valid_o ( {a_w_cap_valid, a_w_valid_o} ),
        .ready_i ( {a_w_cap_ready, a_w_ready_i} )
    );

    stream_fork_2 i_fork_aw_b (
        .clk_i   ( clk_i                          ),
        .rst_ni  ( rst_ni                         ),
        .valid_i ( b_aw_valid_i                   ),
        .ready_o ( b_aw_ready_o                   ),
        .valid_o ( {b_aw_cap_valid, b_aw_valid_o} ),
        .ready_i ( {b_aw_cap_ready, b_aw_ready_i} )
    );

    stream_fork_2 i_fork_w_b (
        .clk_i   ( clk_i                        ),
        .rst_ni  ( rst_ni                       ),
        .valid_i ( b_w_valid_i                  ),
        .ready_o ( b_w_ready_o                  ),
        .valid_o ( {b_w_cap_valid, b_w_valid_o} ),
        .ready_i ( {b_w_cap_ready, b_w_ready_i} )
    );

    // --------------------------------------------------
    // Capture queues
    // --------------------------------------------------
    aw_id_queues #(
        .Depth ( AwDepth )
    ) i_aw_queues_a (
        .clk_i        ( clk_i           ),
        .rst_ni       ( rst_ni          ),
        .aw_i         ( a_aw_i          ),
        .valid_i      ( a_aw_cap_valid  ),
        .ready_o      ( a_aw_cap_ready  ),
        .head_o       ( aw_head_a       ),
        .head_valid_o ( aw_head_valid_a ),
        .pop_i        ( aw_pop          )
    );

    aw_id_queues #(
        .Depth ( AwDepth )
    ) i_aw_queues_b (
        .clk_i        ( clk_i           ),
        .rst_ni       ( rst_ni          ),
        .aw_i         ( b_aw_i          ),
        .valid_i      ( b_aw_cap_valid  ),
        .ready_o      ( b_aw_cap_ready  ),
        .head_o       ( aw_head_b       ),
        .head_valid_o ( aw_head_valid_b ),
        .pop_i        ( aw_pop          )
    );

    cmp_fifo #(
        .Width ( $bits(w_chan_t) ),
        .Depth ( WDepth          )
    ) i_w_fifo_a (
        .clk_i   ( clk_i          ),
        .rst_ni  ( rst_ni         ),
        .data_i  ( a_w_i          ),
        .valid_i ( a_w_cap_valid  ),
        .ready_o ( a_w_cap_ready  ),
        .data_o  ( w_head_a       ),
        .valid_o ( w_head_valid_a ),
        .ready_i ( w_pop          )
    );

    cmp_fifo #(
        .Width ( $bits(w_chan_t) ),
        .Depth ( WDepth          )
    ) i_w_fifo_b (
        .clk_i   ( clk_i          ),
        .rst_ni  ( rst_ni         ),
        .data_i  ( b_w_i          ),
        .valid_i ( b_w_cap_valid  ),
        .ready_o ( b_w_cap_ready  ),
        .data_o  ( w_head_b       ),
        .valid_o ( w_head_valid_b ),
        .ready_i ( w_pop          )
    );

    // --------------------------------------------------
    // Comparison
    // --------------------------------------------------
    mismatch_detect i_mismatch_detect (
        .aw_head_a_i  ( aw_head_a       ),
        .aw_head_b_i  ( aw_head_b       ),
        .aw_valid_a_i ( aw_head_valid_a ),
        .aw_valid_b_i ( aw_head_valid_b ),
        .w_head_a_i   ( w_head_a        ),
        .w_head_b_i   ( w_head_b        ),
        .w_valid_a_i  ( w_head_valid_a  ),
        .w_valid_b_i  ( w_head_valid_b  ),
        .aw_pop_o     ( aw_pop          ),
        .w_pop_o      ( w_pop           ),
        .mismatch_o   ( mismatch_o      ),
        .busy_o       ( busy_o          )
    );

    assign mismatch_any_o = |mismatch_o;

endmodule

//--- logic/mismatch_detect.sv
`timescale 1ns/1ns

module mismatch_detect (
    input  axi_chan_pkg::aw_chan_t [axi_chan_pkg::NumIds-1:0] aw_head_a_i,
    input  axi_chan_pkg::aw_chan_t [axi_chan_pkg::NumIds-1:0] aw_head_b_i,
    input  logic                   [axi_chan_pkg::NumIds-1:0] aw_valid_a_i,
    input  logic                   [axi_chan_pkg::NumIds-1:0] aw_valid_b_i,
    input  axi_chan_pkg::w_chan_t                             w_head_a_i,
    input  axi_chan_pkg::w_chan_t                             w_head_b_i,
    input  logic                                              w_valid_a_i,
    input  logic                                              w_valid_b_i,
    output logic                   [axi_chan_pkg::NumIds-1:0] aw_pop_o,
    output logic                                              w_pop_o,
    output compare_pkg::mismatch_t                            mismatch_o,
    output logic                                              busy_o
);

    import axi_chan_pkg::*;
    import compare_pkg::*;

    // --------------------------------------------------
    // Pairing
    // --------------------------------------------------

    // Both sides hold a head, so the pair leaves together
    assign aw_pop_o = aw_valid_a_i & aw_valid_b_i;
    assign w_pop_o  = w_valid_a_i & w_valid_b_i;

    // --------------------------------------------------
    // Payload comparison
    // --------------------------------------------------
    for (genvar i = 0; i < NumIds; i++) begin : gen_aw_cmp
        assign mismatch_o.aw[i] = aw_pop_o[i] & (aw_head_a_i[i] != aw_head_b_i[i]);
    end

    // Data, strobes and last all count
    assign mismatch_o.w = w_pop_o & (w_head_a_i != w_head_b_i);

    // Any queue still holding an entry
    assign busy_o = (|aw_valid_a_i) | (|aw_valid_b_i) | w_valid_a_i | w_valid_b_i;

endmodule

//--- logic/aw_id_queues.sv
`timescale 1ns/1ns

module aw_id_queues #(
    parameter int unsigned Depth = 4
) (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  axi_chan_pkg::aw_chan_t                                aw_i,
    input  logic                                                  valid_i,
    output logic                                                  ready_o,
    output axi_chan_pkg::aw_chan_t [axi_chan_pkg::NumIds-1:0]     head_o,
    output logic                   [axi_chan_pkg::NumIds-1:0]     head_valid_o,
    input  logic                   [axi_chan_pkg::NumIds-1:0]     pop_i
);

    import axi_chan_pkg::*;

    logic [NumIds-1:0] push_valid;
    logic [NumIds-1:0] push_ready;

    // Steer the beat to the queue of its ID
    always_comb begin
        push_valid             = '0;
        push_valid[aw_i.id]    = valid_i;
        ready_o                = push_ready[aw_i.id];
    end

    // --------------------------------------------------
    // One queue per ID
    // --------------------------------------------------
    for (genvar i = 0; i < NumIds; i++) begin : gen_id_queue
        cmp_fifo #(
            .Width ( $bits(aw_chan_t) ),
            .Depth ( Depth            )
        ) i_cmp_fifo (
            .clk_i   ( clk_i           ),
            .rst_ni  ( rst_ni          ),
            .data_i  ( aw_i            ),
            .valid_i ( push_valid[i]   ),
            .ready_o ( push_ready[i]   ),
            .data_o  ( head_o[i]       ),
            .valid_o ( head_valid_o[i] ),
            .ready_i ( pop_i[i]        )
        );
    end

endmodule

//--- logic/cmp_fifo.sv
`timescale 1ns/1ns

module cmp_fifo #(
    parameter int unsigned Width = 8,
    parameter int unsigned Depth = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [Width-1:0] data_i,
    input  logic             valid_i,
    output logic             ready_o,
    output logic [Width-1:0] data_o,
    output logic             valid_o,
    input  logic             ready_i
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);
    localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);
    localparam logic [CntWidth-1:0] FullCnt = CntWidth'(Depth);

    logic [Width-1:0]    mem [Depth];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                push;
    logic                pop;

    assign ready_o = (count_q != FullCnt);
    assign valid_o = (count_q != '0);
    assign data_o  = mem[rd_ptr_q];

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- logic/stream_fork_2.sv
`timescale 1ns/1ns

module stream_fork_2 (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       valid_i,
    output logic       ready_o,
    output logic [1:0] valid_o,
    input  logic [1:0] ready_i
);

    // Branch has already taken the current beat
    logic [1:0] taken_q;
    logic [1:0] taken_d;
    logic [1:0] done;

    // Offer the beat only to branches still waiting for it
    assign valid_o = {2{valid_i}} & ~taken_q;

    // Finished with this beat, earlier or in this cycle
    assign done = taken_q | (valid_o & ready_i);

    // Upstream completes once both branches are through
    assign ready_o = valid_i & (&done);

    always_comb begin
        if (ready_o) begin
            taken_d = '0;
        end else begin
            taken_d = done;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            taken_q <= '0;
        end else begin
            taken_q <= taken_d;
        end
    end

endmodule

//--- logic/compare_pkg.sv
package compare_pkg;

    // --------------------------------------------------
    // Capture queue sizes
    // --------------------------------------------------

    // Entries per ID in each AW queue
    localparam int unsigned AwDepth = 4;

    // Entries in the W queue of each side
    localparam int unsigned WDepth  = 8;

    // --------------------------------------------------
    // Mismatch report
    // --------------------------------------------------

    // One pulse per compared pair that differs
    typedef struct packed {
        logic [axi_chan_pkg::NumIds-1:0] aw;
        logic                            w;
    } mismatch_t;

endpackage

//--- logic/axi_chan_pkg.sv
package axi_chan_pkg;

    // --------------------------------------------------
    // Bus geometry
    // --------------------------------------------------
    localparam int unsigned IdWidth   = 2;
    localparam int unsigned NumIds    = 2 ** IdWidth;
    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 32;
    localparam int unsigned StrbWidth = DataWidth / 8;

    typedef logic [IdWidth-1:0] id_t;

    // --------------------------------------------------
    // Channel payloads
    // --------------------------------------------------
    typedef struct packed {
        id_t                  id;
        logic [AddrWidth-1:0] addr;
        logic [7:0]           len;
        logic [2:0]           size;
    } aw_chan_t;

    typedef struct packed {
        logic [DataWidth-1:0] data;
        logic [StrbWidth-1:0] strb;
        logic                 last;
    } w_chan_t;

endpackage
